//--- graph_settings.svh
// --------------------------------------
// Global sizing macros for the memory port
// Requestor count, word widths, memory depth
// and response FIFO depth
// --------------------------------------
`ifndef GRAPH_SETTINGS_SVH
`define GRAPH_SETTINGS_SVH

// Engines sharing the scratch memory
`define GRAPH_NUM_REQUESTORS 4

// Word addressing and data
`define GRAPH_ADDR_WIDTH 6
`define GRAPH_DATA_WIDTH 32

// Storage sizes
`define GRAPH_MEM_DEPTH 64
`define GRAPH_FIFO_DEPTH 16

`endif

//--- memory_port_top.sv
// --------------------------------------
// Memory port top level
// Arbiter, scratch memory and response router
// chained into the request/response loop
// --------------------------------------
`timescale 1ns/1ps
`include "graph_settings.svh"

module memory_port_top import pkg_memory::*; (
  input  logic                             ap_clk,
  input  logic                             areset_control,
  input  logic [`GRAPH_NUM_REQUESTORS-1:0] request_valid,
  input  engine_request_t                  request_in [`GRAPH_NUM_REQUESTORS],
  output logic [`GRAPH_NUM_REQUESTORS-1:0] request_ready,
  output logic [`GRAPH_NUM_REQUESTORS-1:0] response_valid,
  output mem_response_t                    response_out [`GRAPH_NUM_REQUESTORS],
  input  logic [`GRAPH_NUM_REQUESTORS-1:0] response_ready
);

  // Arbiter to memory
  logic          arb_valid;
  mem_request_t  arb_request;
  logic          arb_ready;

  // Memory to router
  logic          mem_valid;
  mem_response_t mem_response;
  logic          mem_ready;

  request_arbiter u_arbiter (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .request_valid (request_valid),
    .request_in    (request_in),
    .request_ready (request_ready),
    .arb_valid     (arb_valid),
    .arb_request   (arb_request),
    .arb_ready     (arb_ready)
  );

  scratch_memory u_memory (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .arb_valid     (arb_valid),
    .arb_request   (arb_request),
    .arb_ready     (arb_ready),
    .mem_valid     (mem_valid),
    .mem_response  (mem_response),
    .mem_ready     (mem_ready)
  );

  response_router u_router (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .mem_valid     (mem_valid),
    .mem_response  (mem_response),
    .mem_ready     (mem_ready),
    .response_valid(response_valid),
    .response_out  (response_out),
    .response_ready(response_ready)
  );

endmodule

//--- pkg_control.sv
// --------------------------------------
// Control types
// FIFO status flags and the scratch memory
// state machine encoding
// --------------------------------------

package pkg_control;

  // --------------------------------------
  // FIFO status
  // --------------------------------------
  // almost_full leaves room for entries still in flight
  typedef struct packed {
    logic full;
    logic empty;
    logic almost_full;
  } fifo_status_t;

  // --------------------------------------
  // Scratch memory FSM
  // --------------------------------------
  // Idle or holding a response for the router
  typedef enum logic {
    MEM_IDLE = 1'b0,
    MEM_HOLD = 1'b1
  } mem_state_t;

endpackage

//--- pkg_memory.sv
// --------------------------------------
// Memory packet types
// Addresses, data words, routes, commands,
// engine requests, arbitrated requests and
// memory responses
// --------------------------------------
`include "graph_settings.svh"

package pkg_memory;

  // --------------------------------------
  // Field types
  // --------------------------------------
  typedef logic [`GRAPH_ADDR_WIDTH-1:0] mem_addr_t;
  typedef logic [`GRAPH_DATA_WIDTH-1:0] mem_data_t;

  // One bit per engine, exactly one set
  typedef logic [`GRAPH_NUM_REQUESTORS-1:0] route_mask_t;

  typedef enum logic {
    CMD_READ  = 1'b0,
    CMD_WRITE = 1'b1
  } mem_cmd_t;

  // --------------------------------------
  // Packets
  // --------------------------------------
  // Request as issued by an engine
  typedef struct packed {
    mem_cmd_t  cmd;
    mem_addr_t addr;
    mem_data_t data;
  } engine_request_t;

  // Request after arbitration, tagged with its origin
  typedef struct packed {
    route_mask_t     route;
    engine_request_t req;
  } mem_request_t;

  // Read data or write acknowledgement
  typedef struct packed {
    route_mask_t route;
    mem_cmd_t    cmd;
    mem_addr_t   addr;
    mem_data_t   data;
  } mem_response_t;

endpackage

//--- request_arbiter.sv
// --------------------------------------
// Round-robin request arbiter
// Merges engine requests into one stream and
// tags each with the winner's one-hot route
// --------------------------------------
`timescale 1ns/1ps
`include "graph_settings.svh"

module request_arbiter import pkg_memory::*; (
  input  logic                               ap_clk,
  input  logic                               areset_control,
  input  logic [`GRAPH_NUM_REQUESTORS-1:0]   request_valid,
  input  engine_request_t                    request_in [`GRAPH_NUM_REQUESTORS],
  output logic [`GRAPH_NUM_REQUESTORS-1:0]   request_ready,
  output logic                               arb_valid,
  output mem_request_t                       arb_request,
  input  logic                               arb_ready
);

  localparam int N     = `GRAPH_NUM_REQUESTORS;
  localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

  logic [IDX_W-1:0] rr_ptr;
  logic [IDX_W-1:0] grant_idx;
  route_mask_t      grant;
  logic             found;
  logic             out_free;
  logic             accept;

  // Search from the pointer for the first valid engine
  always_comb begin
    int idx;
    grant     = '0;
    grant_idx = rr_ptr;
    found     = 1'b0;
    for (int off = 0; off < N; off++) begin
      idx = (int'(rr_ptr) + off) % N;
      if (!found && request_valid[idx]) begin
        found      = 1'b1;
        grant[idx] = 1'b1;
        grant_idx  = IDX_W'(idx);
      end
    end
  end

  // Output register empty or draining this cycle
  assign out_free      = ~arb_valid | arb_ready;
  assign request_ready = out_free ? grant : '0;
  assign accept        = found & out_free;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      arb_valid <= 1'b0;
      rr_ptr    <= '0;
    end else begin
      arb_valid <= accept | (arb_valid & ~arb_ready);
      if (accept) begin
        rr_ptr <= (grant_idx == IDX_W'(N - 1)) ? '0 : grant_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (accept) begin
      arb_request.route <= grant;
      arb_request.req   <= request_in[grant_idx];
    end
  end

endmodule

//--- response_router.sv
// --------------------------------------
// One-to-N response router
// Buffers memory responses in a FIFO and hands
// the head to the engine named by its route
// --------------------------------------
`timescale 1ns/1ps
`include "graph_settings.svh"

module response_router import pkg_memory::*, pkg_control::*; (
  input  logic                             ap_clk,
  input  logic                             areset_control,
  input  logic                             mem_valid,
  input  mem_response_t                    mem_response,
  output logic                             mem_ready,
  output logic [`GRAPH_NUM_REQUESTORS-1:0] response_valid,
  output mem_response_t                    response_out [`GRAPH_NUM_REQUESTORS],
  input  logic [`GRAPH_NUM_REQUESTORS-1:0] response_ready
);

  localparam int N      = `GRAPH_NUM_REQUESTORS;
  localparam int RESP_W = $bits(mem_response_t);

  // --------------------------------------
  // Input stage
  // --------------------------------------
  logic          resp_reg_valid;
  mem_response_t resp_reg;
  fifo_status_t  fifo_status;

  // Threshold covers the response sitting in the input register
  assign mem_ready = ~fifo_status.almost_full;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      resp_reg_valid <= 1'b0;
    end else begin
      resp_reg_valid <= mem_valid & mem_ready;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (mem_valid && mem_ready) begin
      resp_reg <= mem_response;
    end
  end

  // --------------------------------------
  // Response FIFO
  // --------------------------------------
  logic              fifo_wr_en;
  logic              fifo_rd_en;
  logic [RESP_W-1:0] fifo_dout;
  mem_response_t     fifo_head;

  assign fifo_wr_en = resp_reg_valid & ~fifo_status.full;
  assign fifo_head  = mem_response_t'(fifo_dout);

  sync_fifo #(
    .WIDTH(RESP_W),
    .DEPTH(`GRAPH_FIFO_DEPTH)
  ) u_resp_fifo (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .wr_en         (fifo_wr_en),
    .din           (resp_reg),
    .rd_en         (fifo_rd_en),
    .dout          (fifo_dout),
    .status        (fifo_status)
  );

  // --------------------------------------
  // Output demux
  // --------------------------------------
  route_mask_t slot_free;
  route_mask_t load_slot;

  // Head waits until its own engine has room
  assign slot_free  = ~response_valid | response_ready;
  assign load_slot  = fifo_status.empty ? '0 : (fifo_head.route & slot_free);
  assign fifo_rd_en = |load_slot;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      response_valid <= '0;
    end else begin
      response_valid <= load_slot | (response_valid & ~response_ready);
    end
  end

  always_ff @(posedge ap_clk) begin
    for (int k = 0; k < N; k++) begin
      if (load_slot[k]) begin
        response_out[k] <= fifo_head;
      end
    end
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile and run the memory port testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module tb_memory_port -o tb_memory_port

output=$(./obj_dir/tb_memory_port)
echo "$output"

if echo "$output" | grep -q "^Result: PASSED$"; then
  exit 0
fi
exit 1

//--- scratch_memory.sv
// --------------------------------------
// Single-port scratch memory
// Executes one request at a time and holds
// the response until the router takes it
// --------------------------------------
`timescale 1ns/1ps
`include "graph_settings.svh"

module scratch_memory import pkg_memory::*, pkg_control::*; (
  input  logic          ap_clk,
  input  logic          areset_control,
  input  logic          arb_valid,
  input  mem_request_t  arb_request,
  output logic          arb_ready,
  output logic          mem_valid,
  output mem_response_t mem_response,
  input  logic          mem_ready
);

  mem_data_t  mem [`GRAPH_MEM_DEPTH];
  mem_state_t state;
  logic       accept;

  // A held response blocks new requests until it leaves
  assign mem_valid = (state == MEM_HOLD);
  assign arb_ready = (state == MEM_IDLE) | mem_ready;
  assign accept    = arb_valid & arb_ready;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      state <= MEM_IDLE;
    end else begin
      case (state)
        MEM_IDLE: if (accept) state <= MEM_HOLD;
        MEM_HOLD: if (mem_ready && !accept) state <= MEM_IDLE;
        default:  state <= MEM_IDLE;
      endcase
    end
  end

  // Array access and response capture
  always_ff @(posedge ap_clk) begin
    if (accept) begin
      mem_response.route <= arb_request.route;
      mem_response.cmd   <= arb_request.req.cmd;
      mem_response.addr  <= arb_request.req.addr;
      if (arb_request.req.cmd == CMD_WRITE) begin
        mem[arb_request.req.addr] <= arb_request.req.data;
        mem_response.data         <= arb_request.req.data;
      end else begin
        mem_response.data <= mem[arb_request.req.addr];
      end
    end
  end

endmodule

//--- sim.f
+incdir+.
pkg_memory.sv
pkg_control.sv
sync_fifo.sv
request_arbiter.sv
scratch_memory.sv
response_router.sv
memory_port_top.sv
tb_memory_port.sv

//--- sync_fifo.sv
// --------------------------------------
// Synchronous FIFO, first word fall through
// Head visible on dout while not empty
// Almost-full flag derived from occupancy
// --------------------------------------
`timescale 1ns/1ps
`include "graph_settings.svh"

module sync_fifo import pkg_control::*; #(
  parameter int WIDTH = `GRAPH_DATA_WIDTH,
  parameter int DEPTH = `GRAPH_FIFO_DEPTH
) (
  input  logic             ap_clk,
  input  logic             areset_control,
  input  logic             wr_en,
  input  logic [WIDTH-1:0] din,
  input  logic             rd_en,
  output logic [WIDTH-1:0] dout,
  output fifo_status_t     status
);

  localparam int PTR_W       = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W       = $clog2(DEPTH + 1);
  localparam int AFULL_LEVEL = DEPTH - 2;

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_write;
  logic             do_read;

  // Overflow and underflow attempts are dropped
  assign do_write = wr_en & ~status.full;
  assign do_read  = rd_en & ~status.empty;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(do_write) - CNT_W'(do_read);
    end
  end

  always_ff @(posedge ap_clk) begin
    if (do_write) begin
      mem[wr_ptr] <= din;
    end
  end

  assign dout               = mem[rd_ptr];
  assign status.full        = (count == CNT_W'(DEPTH));
  assign status.empty       = (count == '0);
  assign status.almost_full = (count >= CNT_W'(AFULL_LEVEL));

endmodule

//--- tb_memory_port.sv
// --------------------------------------
// Testbench for the memory port
// Clock, reset, xorshift stimulus, reference
// model, compare tasks and cycle watchdog
// --------------------------------------
`timescale 1ns/1ps
`include "graph_settings.svh"

module tb_memory_port import pkg_memory::*, pkg_control::*; ();

  localparam int N           = `GRAPH_NUM_REQUESTORS;
  localparam int DEPTH       = `GRAPH_MEM_DEPTH;
  localparam int CYCLE_LIMIT = 20000;

  logic            ap_clk;
  logic            areset_control;
  logic [N-1:0]    request_valid;
  engine_request_t request_in [N];
  logic [N-1:0]    request_ready;
  logic [N-1:0]    response_valid;
  mem_response_t   response_out [N];
  logic [N-1:0]    response_ready;

  // Per-engine stimulus and expected responses
  engine_request_t send_q [N][$];
  mem_response_t   want_q [N][$];
  mem_data_t       model_mem [DEPTH];
  route_mask_t     pop_req;
  logic [31:0]     rng_state;
  int              rr_ptr;
  bit              random_ready;
  bit              window_on;
  route_mask_t     window_seen;
  int              window_count;
  int              cycle_count;
  int              error_count;
  int              check_count;
  int              tests_failed;
  int              test_errors;

  memory_port_top uut (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .request_valid (request_valid),
    .request_in    (request_in),
    .request_ready (request_ready),
    .response_valid(response_valid),
    .response_out  (response_out),
    .response_ready(response_ready)
  );

  always #5 ap_clk = ~ap_clk;

  // Watchdog
  always @(posedge ap_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display("Result: FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] random_word();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // --------------------------------------
  // Compare tasks
  // --------------------------------------
  task automatic check_response(input int eng, input mem_response_t got,
                                input mem_response_t want);
    check_count++;
    if (got !== want) begin
      error_count++;
      $display("** Error at %0t: engine %0d got route=%b cmd=%0d addr=%0d data=%h",
               $time, eng, got.route, got.cmd, got.addr, got.data);
      $display("** Error at %0t: engine %0d expected route=%b cmd=%0d addr=%0d data=%h",
               $time, eng, want.route, want.cmd, want.addr, want.data);
    end
  endtask

  task automatic check_grant(input route_mask_t got, input route_mask_t want,
                             input string what);
    check_count++;
    if (got !== want) begin
      error_count++;
      $display("** Error at %0t: %s is %b, expected %b", $time, what, got, want);
    end
  endtask

  // --------------------------------------
  // Per-cycle monitor and driver
  // --------------------------------------
  task automatic observe();
    route_mask_t     accepted;
    route_mask_t     expect_grant;
    engine_request_t req;
    mem_response_t   want;
    int              idx;
    int              winner;
    accepted = request_valid & request_ready;
    pop_req  = accepted;
    if (accepted != '0) begin
      // Round-robin rule: first valid engine from the pointer
      expect_grant = '0;
      winner       = 0;
      for (int off = N - 1; off >= 0; off--) begin
        idx = (rr_ptr + off) % N;
        if (request_valid[idx]) begin
          winner = idx;
        end
      end
      expect_grant[winner] = 1'b1;
      check_grant(accepted, expect_grant, "accepted set");
      rr_ptr = (winner + 1) % N;
      if (window_on) begin
        window_seen = window_seen | accepted;
        window_count++;
        if (window_count == N) begin
          check_grant(window_seen, '1, "grants in four consecutive accepts");
          window_seen  = '0;
          window_count = 0;
        end
      end
    end
    for (int i = 0; i < N; i++) begin
      if (accepted[i]) begin
        req           = request_in[i];
        want.route    = '0;
        want.route[i] = 1'b1;
        want.cmd      = req.cmd;
        want.addr     = req.addr;
        if (req.cmd == CMD_WRITE) begin
          model_mem[req.addr] = req.data;
          want.data           = req.data;
        end else begin
          want.data = model_mem[req.addr];
        end
        want_q[i].push_back(want);
      end
      if (response_valid[i] && response_ready[i]) begin
        if (want_q[i].size() == 0) begin
          error_count++;
          $display("Engine %0d received a response at %0t that it never asked for", i, $time);
        end else begin
          check_response(i, response_out[i], want_q[i].pop_front());
        end
      end
    end
  endtask

  task automatic drive();
    logic [31:0] r;
    r = random_word();
    for (int i = 0; i < N; i++) begin
      if (pop_req[i]) begin
        void'(send_q[i].pop_front());
      end
      request_valid[i] = (send_q[i].size() > 0);
      if (send_q[i].size() > 0) begin
        request_in[i] = send_q[i][0];
      end
      response_ready[i] = random_ready ? r[i] : 1'b1;
    end
    pop_req = '0;
  endtask

  task automatic step();
    @(negedge ap_clk);
    observe();
    @(posedge ap_clk);
    #1;
    drive();
  endtask

  task automatic run_until_idle();
    bit busy;
    busy = 1'b1;
    while (busy) begin
      step();
      busy = 1'b0;
      for (int i = 0; i < N; i++) begin
        if (send_q[i].size() != 0 || want_q[i].size() != 0) begin
          busy = 1'b1;
        end
      end
    end
  endtask

  // --------------------------------------
  // Stimulus generation
  // --------------------------------------
  task automatic load_random(input int count);
    engine_request_t req;
    logic [31:0]     r;
    for (int i = 0; i < N; i++) begin
      for (int k = 0; k < count; k++) begin
        r        = random_word();
        req.cmd  = r[31] ? CMD_WRITE : CMD_READ;
        req.addr = mem_addr_t'(r[5:0]);
        req.data = random_word();
        send_q[i].push_back(req);
      end
    end
  endtask

  task automatic finish_test(input int num, input string name);
    if (error_count == test_errors) begin
      $display("Test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: failed with %0d errors", num, name, error_count - test_errors);
    end
    test_errors = error_count;
  endtask

  initial begin
    engine_request_t req;
    ap_clk         = 1'b0;
    areset_control = 1'b1;
    request_valid  = '0;
    response_ready = '0;
    for (int i = 0; i < N; i++) begin
      request_in[i] = '0;
    end
    for (int a = 0; a < DEPTH; a++) begin
      model_mem[a] = '0;
    end
    pop_req      = '0;
    rng_state    = 32'hc8e4_7830;
    rr_ptr       = 0;
    random_ready = 1'b0;
    window_on    = 1'b0;
    window_seen  = '0;
    window_count = 0;
    cycle_count  = 0;
    error_count  = 0;
    check_count  = 0;
    tests_failed = 0;
    test_errors  = 0;
    repeat (10) @(posedge ap_clk);
    #1;
    areset_control = 1'b0;
    response_ready = '1;

    // Idle after reset
    repeat (8) begin
      step();
      check_grant(request_ready, '0, "request_ready with no request");
      check_grant(response_valid, '0, "response_valid after reset");
    end
    finish_test(1, "idle after reset");

    // Every engine writes every address, staggered start
    for (int i = 0; i < N; i++) begin
      for (int a = 0; a < DEPTH; a++) begin
        req.cmd  = CMD_WRITE;
        req.addr = mem_addr_t'((a + 16 * i) % DEPTH);
        req.data = random_word();
        send_q[i].push_back(req);
      end
    end
    run_until_idle();
    finish_test(2, "writes to all addresses");

    load_random(40);
    run_until_idle();
    finish_test(3, "random reads and writes");

    random_ready = 1'b1;
    load_random(40);
    run_until_idle();
    random_ready = 1'b0;
    finish_test(4, "response back-pressure");

    window_on = 1'b1;
    load_random(16);
    run_until_idle();
    window_on = 1'b0;
    finish_test(5, "round-robin fairness");

    // Drain and look for stray responses
    repeat (20) step();
    for (int i = 0; i < N; i++) begin
      if (want_q[i].size() != 0) begin
        error_count++;
        $display("Engine %0d still waits for %0d responses after the drain",
                 i, want_q[i].size());
      end
    end
    check_grant(response_valid, '0, "response_valid after drain");
    finish_test(6, "final drain");

    $display("Summary: 6 tests, %0d failed, %0d checks, %0d errors",
             tests_failed, check_count, error_count);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
